// File: hwpe_ctrl_regs.f
hwpe_ctrl_regs_pkg.sv
regfile_access_ctrl.sv
job_id_tracker.sv
mandatory_regs.sv
param_regfile.sv
hwpe_ctrl_regs.sv
tb_hwpe_ctrl_regs.sv

// File: hwpe_ctrl_regs.sv
// HWPE control register file top

`timescale 1ns/1ps

module hwpe_ctrl_regs (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,
  input  logic                                                        clear_i,
  input  logic                                                        req_i,
  input  logic                                                        we_i,
  input  hwpe_ctrl_regs_pkg::addr_t                                   addr_i,
  input  hwpe_ctrl_regs_pkg::word_t                                   wdata_i,
  input  hwpe_ctrl_regs_pkg::be_t                                     be_i,
  input  logic                                                        done_i,
  input  hwpe_ctrl_regs_pkg::ctx_t                                    pointer_context_i,
  input  hwpe_ctrl_regs_pkg::ctx_t                                    running_context_i,
  input  logic                                                        full_context_i,
  input  logic                                                        critical_i,
  output hwpe_ctrl_regs_pkg::word_t                                   rdata_o,
  output hwpe_ctrl_regs_pkg::word_t [hwpe_ctrl_regs_pkg::N_IO_REGS-1:0]      hwpe_params_o,
  output hwpe_ctrl_regs_pkg::word_t [hwpe_ctrl_regs_pkg::N_GENERIC_REGS-1:0] generic_params_o
);

  import hwpe_ctrl_regs_pkg::*;

  logic       param_we;
  logic       param_re;
  store_idx_t store_idx;
  logic       testset;
  logic       trigger;
  logic       mandatory_access;
  reg_idx_t   mand_idx;
  word_t      testset_rdata;
  word_t      mand_rdata;
  word_t      param_rdata;
  job_id_t    running_job_id;

  regfile_access_ctrl i_access_ctrl (
    .clk_i              ( clk_i            ),
    .rst_ni             ( rst_ni           ),
    .clear_i            ( clear_i          ),
    .req_i              ( req_i            ),
    .we_i               ( we_i             ),
    .addr_i             ( addr_i           ),
    .testset_rdata_i    ( testset_rdata    ),
    .mand_rdata_i       ( mand_rdata       ),
    .param_rdata_i      ( param_rdata      ),
    .param_we_o         ( param_we         ),
    .param_re_o         ( param_re         ),
    .store_idx_o        ( store_idx        ),
    .testset_o          ( testset          ),
    .trigger_o          ( trigger          ),
    .mandatory_access_o ( mandatory_access ),
    .mand_idx_o         ( mand_idx         ),
    .rdata_o            ( rdata_o          )
  );

  job_id_tracker i_job_id_tracker (
    .clk_i            ( clk_i          ),
    .rst_ni           ( rst_ni         ),
    .clear_i          ( clear_i        ),
    .testset_i        ( testset        ),
    .critical_i       ( critical_i     ),
    .full_context_i   ( full_context_i ),
    .done_i           ( done_i         ),
    .testset_rdata_o  ( testset_rdata  ),
    .running_job_id_o ( running_job_id )
  );

  mandatory_regs i_mandatory_regs (
    .clk_i              ( clk_i             ),
    .rst_ni             ( rst_ni            ),
    .clear_i            ( clear_i           ),
    .mandatory_access_i ( mandatory_access  ),
    .mand_idx_i         ( mand_idx          ),
    .trigger_i          ( trigger           ),
    .done_i             ( done_i            ),
    .pointer_context_i  ( pointer_context_i ),
    .running_context_i  ( running_context_i ),
    .running_job_id_i   ( running_job_id    ),
    .mand_rdata_o       ( mand_rdata        )
  );

  param_regfile i_param_regfile (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .clear_i           ( clear_i           ),
    .param_we_i        ( param_we          ),
    .param_re_i        ( param_re          ),
    .store_idx_i       ( store_idx         ),
    .wdata_i           ( wdata_i           ),
    .be_i              ( be_i              ),
    .running_context_i ( running_context_i ),
    .param_rdata_o     ( param_rdata       ),
    .hwpe_params_o     ( hwpe_params_o     ),
    .generic_params_o  ( generic_params_o  )
  );

endmodule

// File: hwpe_ctrl_regs_pkg.sv
// Control register file package
// Address map, sizes and word types

package hwpe_ctrl_regs_pkg;

  // Word and field types
  typedef logic [31:0] word_t;
  typedef logic [3:0]  be_t;
  typedef logic [4:0]  addr_t;      // {context, register index}
  typedef logic [3:0]  reg_idx_t;
  typedef logic        ctx_t;
  typedef logic [7:0]  job_id_t;
  typedef logic [3:0]  store_idx_t;
  typedef logic [1:0]  fin_cnt_t;

  // Sizes
  localparam int unsigned N_CONTEXT        = 2;
  localparam int unsigned N_IO_REGS        = 4;
  localparam int unsigned N_GENERIC_REGS   = 4;
  localparam int unsigned N_MANDATORY_REGS = 8;
  localparam int unsigned N_STORE_REGS     = N_GENERIC_REGS + N_CONTEXT * N_IO_REGS;

  // Mandatory register indices, 6 and 7 are unmapped
  localparam reg_idx_t REG_TRIGGER   = 4'd0;
  localparam reg_idx_t REG_ACQUIRE   = 4'd1;
  localparam reg_idx_t REG_FINISHED  = 4'd2;
  localparam reg_idx_t REG_STATUS    = 4'd3;
  localparam reg_idx_t REG_RUNNING   = 4'd4;
  localparam reg_idx_t REG_SOFTCLEAR = 4'd5;

  // Parameter register windows
  localparam reg_idx_t REG_GENERIC_BASE = 4'd8;
  localparam reg_idx_t REG_IO_BASE      = 4'd12;

  // Acquire responses when no id can be handed out
  localparam word_t RESP_ANOTHER_PE_OFFLOADING = 32'hfffffffe;
  localparam word_t RESP_ALL_CXT_BUSY          = 32'hffffffff;

  localparam word_t UNMAPPED_RDATA = 32'hdeadbeef;

  localparam logic [7:0] STATUS_BUSY  = 8'h01;
  localparam fin_cnt_t   FINISHED_MAX = 2'd2;  // Finished counter saturation value

endpackage

// File: job_id_tracker.sv
// Offload and running job id counters

`timescale 1ns/1ps

module job_id_tracker (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  input  logic                        testset_i,
  input  logic                        critical_i,
  input  logic                        full_context_i,
  input  logic                        done_i,
  output hwpe_ctrl_regs_pkg::word_t   testset_rdata_o,
  output hwpe_ctrl_regs_pkg::job_id_t running_job_id_o
);

  import hwpe_ctrl_regs_pkg::*;

  job_id_t offload_id_q;
  job_id_t offload_id_eff;
  logic    offload_incr_q;
  job_id_t running_id_q;
  logic    running_incr_q;

  // Id seen by an acquire, including an increment still in flight
  assign offload_id_eff = offload_id_q + job_id_t'(offload_incr_q);

  // Acquire response and increment request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      testset_rdata_o <= '0;
      offload_incr_q  <= 1'b0;
    end else if (clear_i) begin
      testset_rdata_o <= '0;
      offload_incr_q  <= 1'b0;
    end else if (testset_i) begin
      if (critical_i) begin
        testset_rdata_o <= RESP_ANOTHER_PE_OFFLOADING;
        offload_incr_q  <= 1'b0;
      end else if (full_context_i) begin
        testset_rdata_o <= RESP_ALL_CXT_BUSY;
        offload_incr_q  <= 1'b0;
      end else begin
        testset_rdata_o <= word_t'(offload_id_eff);
        offload_incr_q  <= 1'b1;
      end
    end else begin
      offload_incr_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offload_id_q   <= '0;
      running_incr_q <= 1'b0;
      running_id_q   <= '0;
    end else if (clear_i) begin
      offload_id_q   <= '0;
      running_incr_q <= 1'b0;
      running_id_q   <= '0;
    end else begin
      if (offload_incr_q) offload_id_q <= offload_id_q + 8'd1;
      running_incr_q <= done_i;  // Done is taken one cycle late
      if (running_incr_q) running_id_q <= running_id_q + 8'd1;
    end
  end

  assign running_job_id_o = running_id_q;

endmodule

// File: mandatory_regs.sv
// Mandatory registers: status, finished count, running id

`timescale 1ns/1ps

module mandatory_regs (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  logic                         mandatory_access_i,
  input  hwpe_ctrl_regs_pkg::reg_idx_t mand_idx_i,
  input  logic                         trigger_i,
  input  logic                         done_i,
  input  hwpe_ctrl_regs_pkg::ctx_t     pointer_context_i,
  input  hwpe_ctrl_regs_pkg::ctx_t     running_context_i,
  input  hwpe_ctrl_regs_pkg::job_id_t  running_job_id_i,
  output hwpe_ctrl_regs_pkg::word_t    mand_rdata_o
);

  import hwpe_ctrl_regs_pkg::*;

  logic [N_CONTEXT-1:0][7:0] status_q;
  fin_cnt_t                  finished_q;
  job_id_t                   running_id_q;
  word_t                     status_word;
  word_t                     mand_word;

  // One status byte per context, trigger beats done
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      status_q <= '0;
    end else if (clear_i) begin
      status_q <= '0;
    end else begin
      for (int c = 0; c < N_CONTEXT; c++) begin
        if (trigger_i && (pointer_context_i == ctx_t'(c))) begin
          status_q[c] <= STATUS_BUSY;
        end else if (done_i && (running_context_i == ctx_t'(c))) begin
          status_q[c] <= 8'h00;
        end
      end
    end
  end

  // Bytes above the last context stay zero
  always_comb begin
    status_word = '0;
    for (int c = 0; c < N_CONTEXT; c++) begin
      status_word[c*8 +: 8] = status_q[c];
    end
  end

  // Finished jobs, cleared by any access to FINISHED
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      finished_q <= '0;
    end else if (clear_i) begin
      finished_q <= '0;
    end else if (mandatory_access_i && (mand_idx_i == REG_FINISHED)) begin
      finished_q <= '0;
    end else if (done_i && (finished_q < FINISHED_MAX)) begin
      finished_q <= finished_q + 2'd1;
    end
  end

  always_comb begin
    case (mand_idx_i)
      REG_FINISHED:  mand_word = word_t'(finished_q);
      REG_STATUS:    mand_word = status_word;
      REG_RUNNING:   mand_word = word_t'(running_id_q);
      REG_SOFTCLEAR: mand_word = '0;
      default:       mand_word = UNMAPPED_RDATA;  // Trigger, acquire and holes
    endcase
  end

  // Running id copy and registered readback
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_id_q <= '0;
      mand_rdata_o <= '0;
    end else if (clear_i) begin
      running_id_q <= '0;
      mand_rdata_o <= '0;
    end else begin
      running_id_q <= running_job_id_i;
      if (mandatory_access_i) mand_rdata_o <= mand_word;
    end
  end

endmodule

// File: param_regfile.sv
// Job parameter storage, IO and generic words

`timescale 1ns/1ps

module param_regfile (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,
  input  logic                                                        clear_i,
  input  logic                                                        param_we_i,
  input  logic                                                        param_re_i,
  input  hwpe_ctrl_regs_pkg::store_idx_t                              store_idx_i,
  input  hwpe_ctrl_regs_pkg::word_t                                   wdata_i,
  input  hwpe_ctrl_regs_pkg::be_t                                     be_i,
  input  hwpe_ctrl_regs_pkg::ctx_t                                    running_context_i,
  output hwpe_ctrl_regs_pkg::word_t                                   param_rdata_o,
  output hwpe_ctrl_regs_pkg::word_t [hwpe_ctrl_regs_pkg::N_IO_REGS-1:0]      hwpe_params_o,
  output hwpe_ctrl_regs_pkg::word_t [hwpe_ctrl_regs_pkg::N_GENERIC_REGS-1:0] generic_params_o
);

  import hwpe_ctrl_regs_pkg::*;

  word_t [N_STORE_REGS-1:0] store_q;

  // Byte-enable write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      store_q <= '0;
    end else if (clear_i) begin
      store_q <= '0;
    end else if (param_we_i) begin
      for (int b = 0; b < $bits(be_t); b++) begin
        if (be_i[b]) store_q[store_idx_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
      end
    end
  end

  // Read port, one cycle latency
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      param_rdata_o <= '0;
    end else if (clear_i) begin
      param_rdata_o <= '0;
    end else if (param_re_i) begin
      param_rdata_o <= store_q[store_idx_i];
    end
  end

  // Generic words sit at the bottom of the storage
  always_comb begin
    for (int g = 0; g < N_GENERIC_REGS; g++) begin
      generic_params_o[g] = store_q[g];
    end
  end

  // IO words of the context the engine is running
  always_comb begin
    for (int k = 0; k < N_IO_REGS; k++) begin
      hwpe_params_o[k] = store_q[N_GENERIC_REGS + int'(running_context_i) * N_IO_REGS + k];
    end
  end

endmodule

// File: regfile_access_ctrl.sv
// Bus access decoder and read data select

`timescale 1ns/1ps

module regfile_access_ctrl (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           clear_i,
  input  logic                           req_i,
  input  logic                           we_i,
  input  hwpe_ctrl_regs_pkg::addr_t      addr_i,
  input  hwpe_ctrl_regs_pkg::word_t      testset_rdata_i,
  input  hwpe_ctrl_regs_pkg::word_t      mand_rdata_i,
  input  hwpe_ctrl_regs_pkg::word_t      param_rdata_i,
  output logic                           param_we_o,
  output logic                           param_re_o,
  output hwpe_ctrl_regs_pkg::store_idx_t store_idx_o,
  output logic                           testset_o,
  output logic                           trigger_o,
  output logic                           mandatory_access_o,
  output hwpe_ctrl_regs_pkg::reg_idx_t   mand_idx_o,
  output hwpe_ctrl_regs_pkg::word_t      rdata_o
);

  import hwpe_ctrl_regs_pkg::*;

  reg_idx_t idx;
  ctx_t     ctx;
  logic     is_read;
  logic     is_write;
  logic     is_mand;
  logic     is_io;
  logic     was_testset_q;
  logic     was_mand_q;

  // Address split: low bits index, top bit context
  assign idx = addr_i[$bits(reg_idx_t)-1:0];
  assign ctx = addr_i[$bits(addr_t)-1];

  assign is_read  = req_i & ~we_i;
  assign is_write = req_i & we_i;
  assign is_mand  = (idx < N_MANDATORY_REGS);
  assign is_io    = (idx >= REG_IO_BASE);

  // Storage index per layout rule
  always_comb begin
    if (is_io) begin
      store_idx_o = store_idx_t'(N_GENERIC_REGS)
                  + store_idx_t'(ctx) * store_idx_t'(N_IO_REGS)
                  + store_idx_t'(idx - REG_IO_BASE);
    end else begin
      store_idx_o = store_idx_t'(idx - REG_GENERIC_BASE);  // Generic, context ignored
    end
  end

  assign param_we_o = is_write & ~is_mand;
  assign param_re_o = is_read & ~is_mand;

  assign testset_o          = is_read & (idx == REG_ACQUIRE);
  assign trigger_o          = is_write & (idx == REG_TRIGGER);
  assign mandatory_access_o = req_i & is_mand;
  assign mand_idx_o         = idx;

  // Remember the source of the last read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      was_testset_q <= 1'b0;
      was_mand_q    <= 1'b0;
    end else if (clear_i) begin
      was_testset_q <= 1'b0;
      was_mand_q    <= 1'b0;
    end else if (is_read) begin
      was_testset_q <= testset_o;
      was_mand_q    <= is_mand;
    end
  end

  // Acquire response wins over mandatory readback
  always_comb begin
    if (was_testset_q) begin
      rdata_o = testset_rdata_i;
    end else if (was_mand_q) begin
      rdata_o = mand_rdata_i;
    end else begin
      rdata_o = param_rdata_i;
    end
  end

endmodule

// File: tb_hwpe_ctrl_regs.sv
// Control register file testbench
// Table-driven bus accesses with readback checks

`timescale 1ns/1ps

module tb_hwpe_ctrl_regs;

  import hwpe_ctrl_regs_pkg::*;

  localparam int MAX_ROWS      = 96;
  localparam int RESET_CYCLES  = 16;
  localparam int RESET_TIMEOUT = 64;

  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    word_t wdata;
    be_t   be;
    logic  done;
    ctx_t  ptr;
    ctx_t  run;
    logic  crit;
    logic  full;
    logic  clr;
    logic  chk;    // Compare rdata_o in the following cycle
    word_t exp;
  } row_t;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       clear_i;
  logic                       req_i;
  logic                       we_i;
  addr_t                      addr_i;
  word_t                      wdata_i;
  be_t                        be_i;
  logic                       done_i;
  ctx_t                       pointer_context_i;
  ctx_t                       running_context_i;
  logic                       full_context_i;
  logic                       critical_i;
  word_t                      rdata_o;
  word_t [N_IO_REGS-1:0]      hwpe_params_o;
  word_t [N_GENERIC_REGS-1:0] generic_params_o;

  row_t  rows [MAX_ROWS];
  int    n_rows;
  word_t io_shadow [N_CONTEXT][N_IO_REGS];
  word_t gen_shadow [N_GENERIC_REGS];

  hwpe_ctrl_regs dut0 (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .clear_i           ( clear_i           ),
    .req_i             ( req_i             ),
    .we_i              ( we_i              ),
    .addr_i            ( addr_i            ),
    .wdata_i           ( wdata_i           ),
    .be_i              ( be_i              ),
    .done_i            ( done_i            ),
    .pointer_context_i ( pointer_context_i ),
    .running_context_i ( running_context_i ),
    .full_context_i    ( full_context_i    ),
    .critical_i        ( critical_i        ),
    .rdata_o           ( rdata_o           ),
    .hwpe_params_o     ( hwpe_params_o     ),
    .generic_params_o  ( generic_params_o  )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  initial begin
    rst_ni = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #5;
    rst_ni = 1'b1;
  end

  task automatic add_row(input logic req, input logic we, input addr_t addr, input word_t wdata,
                         input be_t be, input logic done, input ctx_t ptr, input ctx_t run,
                         input logic crit, input logic full, input logic clr, input logic chk,
                         input word_t exp);
    row_t r;
    r = '{req, we, addr, wdata, be, done, ptr, run, crit, full, clr, chk, exp};
    rows[n_rows] = r;
    n_rows++;
  endtask

  task automatic drive_row(input row_t r);
    req_i             = r.req;
    we_i              = r.we;
    addr_i            = r.addr;
    wdata_i           = r.wdata;
    be_i              = r.be;
    done_i            = r.done;
    pointer_context_i = r.ptr;
    running_context_i = r.run;
    critical_i        = r.crit;
    full_context_i    = r.full;
    clear_i           = r.clr;
  endtask

  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  function automatic word_t merge_bytes(input word_t old_word, input word_t new_word, input be_t be);
    word_t res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[b*8 +: 8] = new_word[b*8 +: 8];
    end
    return res;
  endfunction

  // Model of parameter storage, IO window at 12..15 and generic at 8..11
  task automatic update_shadow(input row_t r);
    reg_idx_t idx;
    idx = r.addr[3:0];
    if (r.clr) begin
      for (int c = 0; c < N_CONTEXT; c++) begin
        for (int k = 0; k < N_IO_REGS; k++) io_shadow[c][k] = '0;
      end
      for (int g = 0; g < N_GENERIC_REGS; g++) gen_shadow[g] = '0;
    end else if (r.req && r.we) begin
      if (idx >= REG_IO_BASE) begin
        io_shadow[r.addr[4]][idx - REG_IO_BASE] =
          merge_bytes(io_shadow[r.addr[4]][idx - REG_IO_BASE], r.wdata, r.be);
      end else if (idx >= REG_GENERIC_BASE) begin
        gen_shadow[idx - REG_GENERIC_BASE] =
          merge_bytes(gen_shadow[idx - REG_GENERIC_BASE], r.wdata, r.be);  // Shared by contexts
      end
    end
  endtask

  task automatic check_params(input ctx_t run);
    for (int k = 0; k < N_IO_REGS; k++) begin
      assert (hwpe_params_o[k] === io_shadow[run][k]) else begin
        $display("FAILED hwpe_params_o[%0d]: expected %08h, got %08h",
                 k, io_shadow[run][k], hwpe_params_o[k]);
        abort_run();
      end
    end
    for (int g = 0; g < N_GENERIC_REGS; g++) begin
      assert (generic_params_o[g] === gen_shadow[g]) else begin
        $display("FAILED generic_params_o[%0d]: expected %08h, got %08h",
                 g, gen_shadow[g], generic_params_o[g]);
        abort_run();
      end
    end
  endtask

  // Runs one cycle after the row was applied
  task automatic check_row(input int idx);
    row_t r;
    r = rows[idx];
    update_shadow(r);
    check_params(r.run);
    if (r.chk) begin
      assert (rdata_o === r.exp) else begin
        $display("FAILED rdata_o at row %0d: expected %08h, got %08h", idx, r.exp, rdata_o);
        abort_run();
      end
    end
  endtask

  task automatic build_table();
    n_rows = 0;
    //      req we addr   wdata         be    dn pt rn cr fl cl ck expected
    // Reset state
    add_row(1, 0, 5'h03, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000000);
    add_row(1, 0, 5'h04, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000000);
    add_row(1, 0, 5'h02, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000000);
    add_row(1, 0, 5'h05, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000000);
    add_row(1, 0, 5'h00, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'hdeadbeef);
    add_row(1, 0, 5'h06, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'hdeadbeef);
    add_row(1, 0, 5'h0c, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000000);
    // Parameter writes with partial byte enables
    add_row(1, 1, 5'h0c, 32'h11223344, 4'hf, 0, 0, 0, 0, 0, 0, 0, 32'h00000000);
    add_row(1, 1, 5'h0d, 32'haabbccdd, 4'h3, 0, 0, 0, 0, 0, 0, 0, 32'h00000000);
    add_row(1, 1, 5'h1c, 32'h55667788, 4'hc, 0, 0, 0, 0, 0, 0, 0, 32'h00000000);
    add_row(1, 1, 5'h1f, 32'hcafef00d, 4'hf, 0, 0, 0, 0, 0, 0, 0, 32'h00000000);
    add_row(1, 1, 5'h08, 32'h01020304, 4'h5, 0, 0, 0, 0, 0, 0, 0, 32'h00000000);
    add_row(1, 1, 5'h1b, 32'hdeadc0de, 4'hf, 0, 0, 0, 0, 0, 0, 0, 32'h00000000);
    add_row(1, 1, 5'h0d, 32'h99887766, 4'h8, 0, 0, 0, 0, 0, 0, 0, 32'h00000000);
    add_row(1, 0, 5'h0c, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h11223344);
    add_row(1, 0, 5'h0d, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h9900ccdd);
    add_row(1, 0, 5'h1c, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h55660000);
    add_row(1, 0, 5'h1f, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'hcafef00d);
    add_row(1, 0, 5'h18, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00020004);
    add_row(1, 0, 5'h0b, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'hdeadc0de);
    add_row(0, 0, 5'h00, 32'h00000000, 4'h0, 0, 0, 1, 0, 0, 0, 0, 32'h00000000);
    add_row(1, 0, 5'h1d, 32'h00000000, 4'h0, 0, 0, 1, 0, 0, 0, 1, 32'h00000000);
    // Acquire, critical beats full, refusals keep the id
    add_row(1, 0, 5'h01, 32'h00000000, 4'h0, 0, 0, 0, 1, 0, 0, 1, 32'hfffffffe);
    add_row(1, 0, 5'h01, 32'h00000000, 4'h0, 0, 0, 0, 1, 1, 0, 1, 32'hfffffffe);
    add_row(1, 0, 5'h01, 32'h00000000, 4'h0, 0, 0, 0, 0, 1, 0, 1, 32'hffffffff);
    add_row(1, 0, 5'h01, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000000);
    add_row(1, 0, 5'h01, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000001);
    add_row(1, 0, 5'h01, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000002);
    add_row(1, 0, 5'h01, 32'h00000000, 4'h0, 0, 0, 0, 0, 1, 0, 1, 32'hffffffff);
    add_row(1, 0, 5'h01, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000003);
    // Trigger, done and status bytes
    add_row(1, 1, 5'h00, 32'h00000000, 4'hf, 0, 1, 0, 0, 0, 0, 0, 32'h00000000);
    add_row(1, 0, 5'h03, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000100);
    add_row(1, 1, 5'h00, 32'h00000000, 4'hf, 0, 0, 0, 0, 0, 0, 0, 32'h00000000);
    add_row(1, 0, 5'h03, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000101);
    add_row(0, 0, 5'h00, 32'h00000000, 4'h0, 1, 0, 0, 0, 0, 0, 0, 32'h00000000);
    add_row(1, 0, 5'h03, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000100);
    add_row(0, 0, 5'h00, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 0, 32'h00000000);
    add_row(0, 0, 5'h00, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 0, 32'h00000000);
    add_row(1, 0, 5'h04, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000001);
    add_row(1, 1, 5'h00, 32'h00000000, 4'hf, 1, 0, 0, 0, 0, 0, 0, 32'h00000000);  // Trigger wins
    add_row(1, 0, 5'h03, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000101);
    add_row(0, 0, 5'h00, 32'h00000000, 4'h0, 1, 0, 1, 0, 0, 0, 0, 32'h00000000);
    add_row(1, 0, 5'h03, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000001);
    add_row(0, 0, 5'h00, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 0, 32'h00000000);
    add_row(0, 0, 5'h00, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 0, 32'h00000000);
    add_row(1, 0, 5'h04, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000003);
    // Finished counter saturates and clears on access
    add_row(1, 0, 5'h02, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000002);
    add_row(1, 0, 5'h02, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000000);
    add_row(0, 0, 5'h00, 32'h00000000, 4'h0, 1, 0, 0, 0, 0, 0, 0, 32'h00000000);
    add_row(0, 0, 5'h00, 32'h00000000, 4'h0, 1, 0, 0, 0, 0, 0, 0, 32'h00000000);
    add_row(0, 0, 5'h00, 32'h00000000, 4'h0, 1, 0, 0, 0, 0, 0, 0, 32'h00000000);
    add_row(1, 0, 5'h02, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000002);
    add_row(1, 0, 5'h02, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000000);
    add_row(0, 0, 5'h00, 32'h00000000, 4'h0, 1, 0, 0, 0, 0, 0, 0, 32'h00000000);
    add_row(1, 1, 5'h02, 32'h00000000, 4'hf, 0, 0, 0, 0, 0, 0, 0, 32'h00000000);
    add_row(1, 0, 5'h02, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000000);
    add_row(1, 0, 5'h03, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000000);
    add_row(0, 0, 5'h00, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 0, 32'h00000000);
    add_row(1, 0, 5'h04, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000007);
    // Synchronous clear
    add_row(1, 1, 5'h00, 32'h00000000, 4'hf, 0, 1, 0, 0, 0, 0, 0, 32'h00000000);
    add_row(0, 0, 5'h00, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 1, 1, 32'h00000000);
    add_row(1, 0, 5'h01, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000000);
    add_row(1, 0, 5'h04, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000000);
    add_row(1, 0, 5'h03, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000000);
    add_row(1, 0, 5'h0c, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000000);
    add_row(1, 0, 5'h1f, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000000);
    add_row(1, 0, 5'h0b, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000000);
    add_row(1, 0, 5'h01, 32'h00000000, 4'h0, 0, 0, 0, 0, 0, 0, 1, 32'h00000001);
  endtask

  initial begin
    int cycles;
    drive_row('0);
    for (int c = 0; c < N_CONTEXT; c++) begin
      for (int k = 0; k < N_IO_REGS; k++) io_shadow[c][k] = '0;
    end
    for (int g = 0; g < N_GENERIC_REGS; g++) gen_shadow[g] = '0;
    build_table();
    cycles = 0;
    @(posedge clk_i);
    while (rst_ni !== 1'b1) begin
      if (cycles >= RESET_TIMEOUT) begin
        $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
        abort_run();
      end
      @(posedge clk_i);
      cycles++;
    end
    // Check the previous row before driving the next one
    for (int i = 0; i < n_rows; i++) begin
      @(posedge clk_i);
      #5;
      if (i > 0) check_row(i - 1);
      drive_row(rows[i]);
    end
    @(posedge clk_i);
    #5;
    check_row(n_rows - 1);
    drive_row('0);
    $display("RESULT: PASS");
    $finish;
  end

endmodule
